//--- project.f
rtl/dfdPkg.sv
rtl/dfdCfgIf.sv
rtl/dfdSinkIf.sv
rtl/dfdApbRegs.sv
rtl/dfdDebugMux.sv
rtl/dfdTraceEncoder.sv
rtl/dfdTraceSink.sv
rtl/dfdTop.sv
testbench/dfdTopTb.sv

//--- rtl/dfdApbRegs.sv
module dfdApbRegs
  import dfdPkg::*;
(
  input  logic     i_clk,
  input  logic     i_arstN,
  input  apbAddr_t i_paddr,
  input  logic     i_psel,
  input  logic     i_penable,
  input  logic     i_pwrite,
  input  apbData_t i_pwdata,
  output logic     o_pready,
  output apbData_t o_prdata,
  output logic     o_pslverr,
  dfdCfgIf.regs    cfg,
  dfdSinkIf.regs   sink
);

  logic     access;
  logic     wrEn;
  logic     rdEn;
  logic     addrHit;
  logic     bufEmpty;
  logic     traceEnable;
  logic     changeOnly;
  muxSel_t  muxSel;
  apbData_t ctrlValue;
  apbData_t statusValue;

  // No wait states
  assign o_pready = 1'b1;

  assign access   = i_psel & i_penable;
  assign wrEn     = access & i_pwrite;
  assign rdEn     = access & ~i_pwrite;
  assign bufEmpty = (sink.level == '0);

  // **************************************************
  // Control register
  // **************************************************
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      traceEnable <= 1'b0;
      changeOnly  <= 1'b0;
      muxSel      <= '0;
    end else if (wrEn && (i_paddr == RegCtrl)) begin
      traceEnable <= i_pwdata[CtrlEnableBit];
      changeOnly  <= i_pwdata[CtrlChangeOnlyBit];
      muxSel      <= i_pwdata[CtrlMuxSelLsb +: MuxSelWidth];
    end
  end

  assign cfg.traceEnable = traceEnable;
  assign cfg.changeOnly  = changeOnly;
  assign cfg.muxSel      = muxSel;

  always_comb begin
    ctrlValue                                    = '0;
    ctrlValue[CtrlEnableBit]                     = traceEnable;
    ctrlValue[CtrlChangeOnlyBit]                 = changeOnly;
    ctrlValue[CtrlMuxSelLsb +: MuxSelWidth]      = muxSel;
    statusValue                                  = '0;
    statusValue[SinkLevelWidth-1:0]              = sink.level;
    statusValue[StatusOvfBit]                    = sink.overflow;
  end

  // **************************************************
  // Read mux and error response
  // **************************************************
  always_comb begin
    addrHit  = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      RegCtrl:   o_prdata = ctrlValue;
      RegStatus: o_prdata = statusValue;
      RegData:   o_prdata = bufEmpty ? '0 : sink.rdData;
      RegTime:   o_prdata = apbData_t'(cfg.timestamp);
      default:   addrHit  = 1'b0;
    endcase
  end

  // Empty data read is an error as well
  assign o_pslverr = i_psel &
                     (~addrHit | (~i_pwrite & (i_paddr == RegData) & bufEmpty));

  // Strobes land on the access-cycle edge
  assign sink.pop    = rdEn & (i_paddr == RegData) & ~bufEmpty;
  assign sink.ovfClr = wrEn & (i_paddr == RegStatus) & i_pwdata[StatusOvfBit];

endmodule

//--- rtl/dfdCfgIf.sv
interface dfdCfgIf
  import dfdPkg::*;
();

  logic    traceEnable;
  logic    changeOnly;
  muxSel_t muxSel;
  tstamp_t timestamp;

  // Register block owns the trace configuration
  modport regs (
    output traceEnable,
    output changeOnly,
    output muxSel,
    input  timestamp
  );

  modport enc (
    input  traceEnable,
    input  changeOnly,
    output timestamp
  );

  modport mux (
    input muxSel
  );

endinterface

//--- rtl/dfdDebugMux.sv
module dfdDebugMux
  import dfdPkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_arstN,
  input  hwWord_t [NumHwGroups-1:0] i_hw,
  dfdCfgIf.mux                      cfg,
  output hwWord_t                   o_dbgWord
);

  hwWord_t selWord;

  // **************************************************
  // Group select
  // **************************************************
  always_comb begin
    selWord = '0;
    for (int i = 0; i < NumHwGroups; i++) begin
      if (cfg.muxSel == muxSel_t'(i)) begin
        selWord = i_hw[i];
      end
    end
  end

  // One stage aligns the debug bus with the encoder
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_dbgWord <= '0;
    end else begin
      o_dbgWord <= selWord;
    end
  end

endmodule

//--- rtl/dfdPkg.sv
package dfdPkg;

  // **************************************************
  // Widths
  // **************************************************
  localparam int NumHwGroups    = 16;
  localparam int SinkDepth      = 16;
  localparam int HwWordWidth    = 16;
  localparam int MuxSelWidth    = $clog2(NumHwGroups);
  localparam int TstampWidth    = 16;
  localparam int PacketWidth    = TstampWidth + HwWordWidth;
  localparam int ApbAddrWidth   = 12;
  localparam int ApbDataWidth   = 32;
  localparam int SinkPtrWidth   = $clog2(SinkDepth);
  localparam int SinkLevelWidth = SinkPtrWidth + 1;

  typedef logic [HwWordWidth-1:0]    hwWord_t;
  typedef logic [MuxSelWidth-1:0]    muxSel_t;
  typedef logic [TstampWidth-1:0]    tstamp_t;
  // Timestamp in the upper half, debug word in the lower half
  typedef logic [PacketWidth-1:0]    packet_t;
  typedef logic [ApbAddrWidth-1:0]   apbAddr_t;
  typedef logic [ApbDataWidth-1:0]   apbData_t;
  typedef logic [SinkLevelWidth-1:0] sinkLevel_t;

  typedef enum logic {
    TraceOff,
    TraceOn
  } TraceState_e;

  // **************************************************
  // Register map
  // **************************************************
  localparam apbAddr_t RegCtrl   = 12'h000;
  localparam apbAddr_t RegStatus = 12'h004;
  localparam apbAddr_t RegData   = 12'h008;
  localparam apbAddr_t RegTime   = 12'h00C;

  localparam int CtrlEnableBit     = 0;
  localparam int CtrlChangeOnlyBit = 1;
  localparam int CtrlMuxSelLsb     = 4;
  localparam int StatusOvfBit      = 16;

endpackage

//--- rtl/dfdSinkIf.sv
interface dfdSinkIf
  import dfdPkg::*;
();

  logic       pop;
  packet_t    rdData;
  sinkLevel_t level;
  logic       overflow;
  logic       ovfClr;

  // Pop and ovfClr are single-cycle strobes
  modport regs (
    output pop,
    output ovfClr,
    input  rdData,
    input  level,
    input  overflow
  );

  modport sink (
    input  pop,
    input  ovfClr,
    output rdData,
    output level,
    output overflow
  );

endinterface

//--- rtl/dfdTop.sv
module dfdTop
  import dfdPkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_arstN,
  input  hwWord_t [NumHwGroups-1:0] i_hw,
  input  logic                      i_timeTick,
  input  logic                      i_traceStart,
  input  logic                      i_traceStop,
  input  logic                      i_tracePulse,
  input  apbAddr_t                  i_paddr,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  apbData_t                  i_pwdata,
  output logic                      o_pready,
  output apbData_t                  o_prdata,
  output logic                      o_pslverr,
  output logic                      o_traceActive
);

  hwWord_t dbgWord;
  logic    push;
  packet_t packet;

  dfdCfgIf  cfgIf ();
  dfdSinkIf sinkIf ();

  dfdApbRegs uApbRegs (
    .i_clk     (i_clk),
    .i_arstN   (i_arstN),
    .i_paddr   (i_paddr),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_pwdata  (i_pwdata),
    .o_pready  (o_pready),
    .o_prdata  (o_prdata),
    .o_pslverr (o_pslverr),
    .cfg       (cfgIf.regs),
    .sink      (sinkIf.regs)
  );

  dfdDebugMux uDebugMux (
    .i_clk     (i_clk),
    .i_arstN   (i_arstN),
    .i_hw      (i_hw),
    .cfg       (cfgIf.mux),
    .o_dbgWord (dbgWord)
  );

  // Encoder to sink is a bare push strobe
  dfdTraceEncoder uTraceEncoder (
    .i_clk         (i_clk),
    .i_arstN       (i_arstN),
    .i_dbgWord     (dbgWord),
    .i_timeTick    (i_timeTick),
    .i_traceStart  (i_traceStart),
    .i_traceStop   (i_traceStop),
    .i_tracePulse  (i_tracePulse),
    .cfg           (cfgIf.enc),
    .o_push        (push),
    .o_packet      (packet),
    .o_traceActive (o_traceActive)
  );

  dfdTraceSink uTraceSink (
    .i_clk    (i_clk),
    .i_arstN  (i_arstN),
    .i_push   (push),
    .i_packet (packet),
    .sink     (sinkIf.sink)
  );

endmodule

//--- rtl/dfdTraceEncoder.sv
module dfdTraceEncoder
  import dfdPkg::*;
(
  input  logic    i_clk,
  input  logic    i_arstN,
  input  hwWord_t i_dbgWord,
  input  logic    i_timeTick,
  input  logic    i_traceStart,
  input  logic    i_traceStop,
  input  logic    i_tracePulse,
  dfdCfgIf.enc    cfg,
  output logic    o_push,
  output packet_t o_packet,
  output logic    o_traceActive
);

  TraceState_e state;
  TraceState_e nextState;
  tstamp_t     tstamp;
  hwWord_t     lastWord;
  logic        lastValid;
  logic        entering;
  logic        traceCap;
  logic        pulseCap;
  logic        capture;

  // **************************************************
  // Timestamp
  // **************************************************
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      tstamp <= '0;
    end else if (i_timeTick) begin
      tstamp <= tstamp + 1'b1;
    end
  end

  assign cfg.timestamp = tstamp;

  // **************************************************
  // Trace on/off FSM
  // **************************************************
  always_comb begin
    nextState = state;
    case (state)
      TraceOff: begin
        // Stop wins over a simultaneous start
        if (cfg.traceEnable && i_traceStart && !i_traceStop) begin
          nextState = TraceOn;
        end
      end
      TraceOn: begin
        if (i_traceStop || !cfg.traceEnable) begin
          nextState = TraceOff;
        end
      end
      default: nextState = TraceOff;
    endcase
  end

  assign entering = (state == TraceOff) & (nextState == TraceOn);

  // First sample of a run always passes the change filter
  assign traceCap = (state == TraceOn) &
                    (~cfg.changeOnly | ~lastValid | (i_dbgWord != lastWord));
  assign pulseCap = i_tracePulse & cfg.traceEnable;
  assign capture  = traceCap | pulseCap;

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      state     <= TraceOff;
      o_push    <= 1'b0;
      lastValid <= 1'b0;
    end else begin
      state  <= nextState;
      o_push <= capture;
      if (entering) begin
        lastValid <= 1'b0;
      end else if (capture) begin
        lastValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_packet <= {tstamp, i_dbgWord};
      lastWord <= i_dbgWord;
    end
  end

  assign o_traceActive = (state == TraceOn);

endmodule

//--- rtl/dfdTraceSink.sv
module dfdTraceSink
  import dfdPkg::*;
(
  input  logic    i_clk,
  input  logic    i_arstN,
  input  logic    i_push,
  input  packet_t i_packet,
  dfdSinkIf.sink  sink
);

  packet_t                 mem [SinkDepth];
  logic [SinkPtrWidth-1:0] wrPtr;
  logic [SinkPtrWidth-1:0] rdPtr;
  sinkLevel_t              level;
  logic                    overflow;
  logic                    full;
  logic                    pushOk;

  assign full   = (level == sinkLevel_t'(SinkDepth));
  assign pushOk = i_push & ~full;

  // **************************************************
  // Packet storage
  // **************************************************
  always_ff @(posedge i_clk) begin
    if (pushOk) begin
      mem[wrPtr] <= i_packet;
    end
  end

  // Pointers wrap at the buffer depth
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (pushOk) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (sink.pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({pushOk, sink.pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      // A new drop beats a clear in the same cycle
      if (i_push && full) begin
        overflow <= 1'b1;
      end else if (sink.ovfClr) begin
        overflow <= 1'b0;
      end
    end
  end

  assign sink.rdData   = mem[rdPtr];
  assign sink.level    = level;
  assign sink.overflow = overflow;

endmodule

//--- testbench/dfdTopTb.sv
module dfdTopTb
  import dfdPkg::*;
();

  // Row fields are mode, ctrl, sel, ticks, hold, pattern length, pattern,
  // expected count, expected pattern and expected overflow
  typedef struct packed {
    logic            runMode;
    apbData_t        ctrl;
    muxSel_t         sel;
    logic [7:0]      ticks;
    logic [7:0]      hold;
    logic [3:0]      patLen;
    logic [7:0][3:0] pat;
    logic [4:0]      expLen;
    logic [7:0][3:0] expPat;
    logic            expOvf;
  } testRow_t;

  logic                      clk;
  logic                      arstN;
  hwWord_t [NumHwGroups-1:0] hw;
  logic                      timeTick;
  logic                      traceStart;
  logic                      traceStop;
  logic                      tracePulse;
  apbAddr_t                  paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  apbData_t                  pwdata;
  logic                      pready;
  apbData_t                  prdata;
  logic                      pslverr;
  logic                      traceActive;

  integer   seed;
  tstamp_t  tsModel;
  hwWord_t  pool [NumHwGroups];
  testRow_t rows [5];
  string    rowName [5];

  dfdTop dut (
    .i_clk         (clk),
    .i_arstN       (arstN),
    .i_hw          (hw),
    .i_timeTick    (timeTick),
    .i_traceStart  (traceStart),
    .i_traceStop   (traceStop),
    .i_tracePulse  (tracePulse),
    .i_paddr       (paddr),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr),
    .o_traceActive (traceActive)
  );

  always #2 clk = ~clk;

  // **************************************************
  // Failure and compare tasks
  // **************************************************
  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic checkPacket(input string name, input packet_t exp, input packet_t act);
    if (act !== exp) begin
      abortRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkLevel(input string name, input sinkLevel_t exp, input sinkLevel_t act);
    if (act !== exp) begin
      abortRun($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic checkTime(input string name, input tstamp_t exp, input tstamp_t act);
    if (act !== exp) begin
      abortRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkApbData(input string name, input apbData_t exp, input apbData_t act);
    if (act !== exp) begin
      abortRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkErrBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abortRun($sformatf("** Error %s: expected pslverr %b, actual %b", name, exp, act));
    end
  endtask

  // **************************************************
  // Bus and stimulus tasks
  // **************************************************
  task automatic apbXfer(input logic wr, input apbAddr_t addr, input apbData_t wdata,
                         output apbData_t data, output logic err);
    int waitCnt;
    waitCnt = 0;
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (pready !== 1'b1) begin
      waitCnt++;
      if (waitCnt > 16) begin
        abortRun("Timeout: APB transfer never saw o_pready high");
      end
      @(negedge clk);
    end
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input apbAddr_t addr, input apbData_t wdata);
    apbData_t unused;
    logic     unusedErr;
    apbXfer(1'b1, addr, wdata, unused, unusedErr);
  endtask

  task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err);
    apbXfer(1'b0, addr, '0, data, err);
  endtask

  task automatic applyTicks(input int n);
    if (n > 0) begin
      repeat (n) begin
        @(posedge clk);
        #1;
        timeTick = 1'b1;
      end
      @(posedge clk);
      #1;
      timeTick = 1'b0;
      tsModel  = tsModel + tstamp_t'(n);
    end
  endtask

  // Selected group holds its value while the others keep changing
  task automatic holdValue(input muxSel_t sel, input hwWord_t value, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      for (int g = 0; g < NumHwGroups; g++) begin
        hw[g] = (g == sel) ? value : hwWord_t'($random(seed));
      end
    end
  endtask

  task automatic driveStrobe(input logic st, input logic sp, input logic pl);
    @(posedge clk);
    #1;
    traceStart = st;
    traceStop  = sp;
    tracePulse = pl;
    @(posedge clk);
    #1;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
  endtask

  task automatic waitLevel(input string name, input sinkLevel_t exp);
    apbData_t d;
    logic     e;
    int       n;
    n = 0;
    apbRead(RegStatus, d, e);
    while ((sinkLevel_t'(d[SinkLevelWidth-1:0]) !== exp) && (n < 8)) begin
      n++;
      apbRead(RegStatus, d, e);
    end
    checkLevel(name, exp, sinkLevel_t'(d[SinkLevelWidth-1:0]));
  endtask

  task automatic waitActive(input string name, input logic exp);
    int n;
    n = 0;
    while (traceActive !== exp) begin
      n++;
      if (n > 16) begin
        abortRun($sformatf("Timeout: o_traceActive never became %b in %s", exp, name));
      end
      @(negedge clk);
    end
  endtask

  // **************************************************
  // Test sequences
  // **************************************************
  task automatic loadTable();
    rowName[0] = "pulseSel3";
    rows[0] = {1'b0, 32'h1, 4'd3, 8'd5, 8'd3, 4'd2, 32'h0000_0072, 5'd2, 32'h0000_0072, 1'b0};
    rowName[1] = "pulseSel12";
    rows[1] = {1'b0, 32'h1, 4'd12, 8'd3, 8'd3, 4'd3, 32'h0000_0B95, 5'd3, 32'h0000_0B95, 1'b0};
    rowName[2] = "pulseDisabled";
    rows[2] = {1'b0, 32'h0, 4'd6, 8'd2, 8'd3, 4'd1, 32'h0000_0001, 5'd0, 32'h0, 1'b0};
    rowName[3] = "changeOnly";
    rows[3] = {1'b1, 32'h3, 4'd9, 8'd4, 8'd4, 4'd8, 32'h1124_4411, 5'd4, 32'h0000_1241, 1'b0};
    rowName[4] = "continuous";
    rows[4] = {1'b1, 32'h1, 4'd14, 8'd7, 8'd24, 4'd1, 32'h0000_0008, 5'd16, 32'h8888_8888, 1'b1};
  endtask

  task automatic regAccessTest();
    apbData_t d;
    logic     e;
    apbRead(RegCtrl, d, e);
    checkApbData("ctrlAfterReset", '0, d);
    checkErrBit("ctrlAfterReset", 1'b0, e);
    apbWrite(RegCtrl, 32'hFFFF_FFFF);
    apbRead(RegCtrl, d, e);
    checkApbData("ctrlReadback",
                 (32'h1 << CtrlEnableBit) | (32'h1 << CtrlChangeOnlyBit) |
                 (32'hF << CtrlMuxSelLsb), d);
    apbWrite(RegCtrl, '0);
    applyTicks(9);
    apbRead(RegTime, d, e);
    checkTime("timeRead", tsModel, tstamp_t'(d));
    apbWrite(RegTime, 32'h0000_1234);
    apbRead(RegTime, d, e);
    checkTime("timeReadOnly", tsModel, tstamp_t'(d));
    apbWrite(RegStatus, 32'h0000_FFFF);
    apbRead(RegStatus, d, e);
    checkApbData("statusIgnoresWrite", '0, d);
    apbRead(12'h010, d, e);
    checkApbData("unmappedData", '0, d);
    checkErrBit("unmappedErr", 1'b1, e);
    apbRead(RegData, d, e);
    checkApbData("emptyData", '0, d);
    checkErrBit("emptyErr", 1'b1, e);
    waitLevel("emptyLevel", '0);
  endtask

  task automatic runRow(input int r);
    testRow_t row;
    apbData_t d;
    logic     e;
    apbData_t expStatus;
    row = rows[r];
    applyTicks(row.ticks);
    apbWrite(RegCtrl, row.ctrl | (apbData_t'(row.sel) << CtrlMuxSelLsb));
    if (!row.runMode) begin
      for (int k = 0; k < row.patLen; k++) begin
        holdValue(row.sel, pool[row.pat[k]], row.hold);
        driveStrobe(1'b0, 1'b0, 1'b1);
      end
    end else begin
      holdValue(row.sel, pool[row.pat[0]], 3);
      driveStrobe(1'b1, 1'b0, 1'b0);
      for (int k = 0; k < row.patLen; k++) begin
        holdValue(row.sel, pool[row.pat[k]], row.hold);
      end
      driveStrobe(1'b0, 1'b1, 1'b0);
    end
    waitLevel(rowName[r], sinkLevel_t'(row.expLen));
    expStatus = apbData_t'(row.expLen) | (apbData_t'(row.expOvf) << StatusOvfBit);
    apbRead(RegStatus, d, e);
    checkApbData(rowName[r], expStatus, d);
    // Expected list repeats past eight entries
    for (int i = 0; i < row.expLen; i++) begin
      apbRead(RegData, d, e);
      checkErrBit(rowName[r], 1'b0, e);
      checkPacket(rowName[r], {tsModel, pool[row.expPat[i % 8]]}, packet_t'(d));
    end
    if (row.expOvf) begin
      apbWrite(RegStatus, apbData_t'(1) << StatusOvfBit);
    end
    apbRead(RegStatus, d, e);
    checkApbData(rowName[r], '0, d);
    apbRead(RegData, d, e);
    checkErrBit(rowName[r], 1'b1, e);
    apbWrite(RegCtrl, '0);
  endtask

  task automatic startStopTest();
    apbWrite(RegCtrl, '0);
    driveStrobe(1'b1, 1'b0, 1'b0);
    waitActive("startDisabled", 1'b0);
    apbWrite(RegCtrl, apbData_t'(1) << CtrlEnableBit);
    driveStrobe(1'b1, 1'b0, 1'b0);
    waitActive("startEnabled", 1'b1);
    driveStrobe(1'b0, 1'b1, 1'b0);
    waitActive("stop", 1'b0);
    driveStrobe(1'b1, 1'b1, 1'b0);
    waitActive("startStopTogether", 1'b0);
    driveStrobe(1'b1, 1'b0, 1'b0);
    waitActive("restart", 1'b1);
    apbWrite(RegCtrl, '0);
    waitActive("enableCleared", 1'b0);
  endtask

  initial begin
    int rnd;
    seed       = 32'hfa51;
    tsModel    = '0;
    clk        = 1'b0;
    arstN      = 1'b0;
    timeTick   = 1'b0;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    // Upper nibble keeps pool values distinct
    for (int i = 0; i < NumHwGroups; i++) begin
      rnd     = $random(seed);
      pool[i] = hwWord_t'((i << 12) | (rnd & 32'h0FFF));
      hw[i]   = hwWord_t'($random(seed));
    end
    loadTable();
    repeat (16) @(posedge clk);
    #1;
    arstN = 1'b1;
    regAccessTest();
    for (int r = 0; r < $size(rows); r++) begin
      runRow(r);
    end
    startStopTest();
    $display("Done: no errors");
    $finish;
  end

endmodule
